/* rtl/rf_pkg.sv */
package rf_pkg;

   // Register width and serial bit counter width
   localparam int RF_XLEN  = 32;
   localparam int RF_CNT_W = 5;

   // Six address bits cover 32 GPRs plus the CSR block
   localparam int RF_AW    = 6;
   localparam int RF_DEPTH = 36;

   // Upper address nibble of every CSR slot, 32..35
   localparam logic [3:0] CSR_MARKER = 4'b1000;

   // CSR slot numbers within the CSR block
   localparam logic [1:0] CSR_MSCRATCH = 2'd0;
   localparam logic [1:0] CSR_MTVEC    = 2'd1;
   localparam logic [1:0] CSR_MEPC     = 2'd2;
   localparam logic [1:0] CSR_MTVAL    = 2'd3;

   // GPR view, top bit clear
   typedef struct packed {
      logic       zero;
      logic [4:0] idx;
   } rf_gpr_t;

   // CSR view, marker 1000 then slot
   typedef struct packed {
      logic [3:0] marker;
      logic [1:0] slot;
   } rf_csr_t;

   // One address word, read either way
   typedef union packed {
      rf_gpr_t gpr;
      rf_csr_t csr;
   } rf_addr_u;

   // Sequencer states
   typedef enum logic [1:0] {
      ST_IDLE,
      ST_LOAD,
      ST_RUN,
      ST_COMMIT
   } rf_state_e;

endpackage

/* rtl/rf_seq_ctrl.sv */
`timescale 1ns/1ps

module rf_seq_ctrl (
   input  logic i_clk,
   input  logic i_rst_n,
   input  logic i_go,
   input  logic i_cnt_last,
   output logic o_ready,
   output logic o_load,
   output logic o_cnt_en,
   output logic o_commit
);

   import rf_pkg::*;

   rf_state_e state;
   rf_state_e state_nxt;

   // Next state
   always_comb begin
      state_nxt = state;
      case (state)
         ST_IDLE: begin
            // Accept only here
            if (i_go) begin
               state_nxt = ST_LOAD;
            end
         end
         ST_LOAD: begin
            state_nxt = ST_RUN;
         end
         ST_RUN: begin
            // Leave after bit 31
            if (i_cnt_last) begin
               state_nxt = ST_COMMIT;
            end
         end
         ST_COMMIT: begin
            state_nxt = ST_IDLE;
         end
         default: begin
            state_nxt = ST_IDLE;
         end
      endcase
   end

   always_ff @(posedge i_clk or negedge i_rst_n) begin
      if (!i_rst_n) begin
         state <= ST_IDLE;
      end else begin
         state <= state_nxt;
      end
   end

   // Phase strobes decoded straight from state
   assign o_ready  = (state == ST_IDLE);
   assign o_load   = (state == ST_LOAD);
   assign o_cnt_en = (state == ST_RUN);
   assign o_commit = (state == ST_COMMIT);

   // One-cycle commit right after the 32nd run bit
   a_commit_one_cycle : assert property (@(posedge i_clk) disable iff (!i_rst_n)
      o_load |=> !i_cnt_last [*31] ##1 i_cnt_last ##1 o_commit ##1 !o_commit);

   // Busy for 34 cycles after acceptance whatever i_go does
   a_go_ignored_busy : assert property (@(posedge i_clk) disable iff (!i_rst_n)
      (i_go && o_ready) |=> !o_ready [*34] ##1 o_ready);

endmodule

/* rtl/rf_bit_counter.sv */
`timescale 1ns/1ps

module rf_bit_counter (
   input  logic i_clk,
   input  logic i_rst_n,
   input  logic i_cnt_en,
   output logic o_cnt_last
);

   import rf_pkg::*;

   logic [RF_CNT_W-1:0] cnt;

   // Bit position, wraps to 0 after 31
   always_ff @(posedge i_clk or negedge i_rst_n) begin
      if (!i_rst_n) begin
         cnt <= '0;
      end else if (i_cnt_en) begin
         cnt <= cnt + 1'b1;
      end
   end

   // Last bit of the word
   assign o_cnt_last = i_cnt_en & (&cnt);

endmodule

/* rtl/rf_if.sv */
`timescale 1ns/1ps

module rf_if #(
   parameter int WITH_CSR = 1
) (
   // Trap side
   input  logic                     i_trap,
   input  logic                     i_mret,
   input  logic                     i_mepc,
   input  logic                     i_mem_op,
   input  logic                     i_bufreg_q,
   input  logic                     i_bad_pc,
   // CSR access
   input  logic                     i_csr_en,
   input  logic [1:0]               i_csr_addr,
   input  logic                     i_csr,
   // rd write sources
   input  logic                     i_rd_wen,
   input  logic [rf_pkg::RF_AW-2:0] i_rd_waddr,
   input  logic                     i_ctrl_rd,
   input  logic                     i_alu_rd,
   input  logic                     i_rd_alu_en,
   input  logic                     i_csr_rd,
   input  logic                     i_rd_csr_en,
   input  logic                     i_mem_rd,
   // Source register indices
   input  logic [rf_pkg::RF_AW-2:0] i_rs1_raddr,
   input  logic [rf_pkg::RF_AW-2:0] i_rs2_raddr,
   // Serial read bits from the port shifters
   input  logic                     i_rdata0,
   input  logic                     i_rdata1,
   // Port side
   output logic [rf_pkg::RF_AW-1:0] o_wreg0,
   output logic [rf_pkg::RF_AW-1:0] o_wreg1,
   output logic                     o_wen0,
   output logic                     o_wen1,
   output logic                     o_wdata0,
   output logic                     o_wdata1,
   output logic [rf_pkg::RF_AW-1:0] o_rreg0,
   output logic [rf_pkg::RF_AW-1:0] o_rreg1,
   // Serial results
   output logic                     o_rs1,
   output logic                     o_rs2,
   output logic                     o_csr,
   output logic                     o_csr_pc
);

   import rf_pkg::*;

   rf_addr_u wreg0_u;
   rf_addr_u wreg1_u;
   rf_addr_u rreg1_u;
   logic     rd_wen;

   // x0 never written
   assign rd_wen = i_rd_wen & (|i_rd_waddr);

   // rs1 always a GPR on port 0
   assign o_rreg0 = {1'b0, i_rs1_raddr};
   assign o_rs1   = i_rdata0;
   assign o_rs2   = i_rdata1;

   generate
      if (WITH_CSR != 0) begin : g_csr
         logic rd_bit;
         logic mtval_bit;

         // Disabled sources drop out of the OR
         assign rd_bit = i_ctrl_rd | (i_alu_rd & i_rd_alu_en) |
                         (i_csr_rd & i_rd_csr_en) | i_mem_rd;

         // Faulting address or bad PC
         assign mtval_bit = i_mem_op ? i_bufreg_q : i_bad_pc;

         assign o_wdata0 = i_trap ? mtval_bit : rd_bit;
         assign o_wdata1 = i_trap ? i_mepc : i_csr;
         assign o_wen0   = i_trap | rd_wen;
         assign o_wen1   = i_trap | i_csr_en;

         // Port 0 takes rd, or MTVAL on trap
         always_comb begin
            if (i_trap) begin
               wreg0_u.csr.marker = CSR_MARKER;
               wreg0_u.csr.slot   = CSR_MTVAL;
            end else begin
               wreg0_u.gpr.zero = 1'b0;
               wreg0_u.gpr.idx  = i_rd_waddr;
            end
         end

         // Port 1 is always a CSR slot
         always_comb begin
            wreg1_u.csr.marker = CSR_MARKER;
            wreg1_u.csr.slot   = i_trap ? CSR_MEPC : i_csr_addr;
         end

         // Read port 1 priority trap, mret, CSR, rs2
         always_comb begin
            if (i_trap) begin
               rreg1_u.csr.marker = CSR_MARKER;
               rreg1_u.csr.slot   = CSR_MTVEC;
            end else if (i_mret) begin
               rreg1_u.csr.marker = CSR_MARKER;
               rreg1_u.csr.slot   = CSR_MEPC;
            end else if (i_csr_en) begin
               rreg1_u.csr.marker = CSR_MARKER;
               rreg1_u.csr.slot   = i_csr_addr;
            end else begin
               rreg1_u.gpr.zero = 1'b0;
               rreg1_u.gpr.idx  = i_rs2_raddr;
            end
         end

         // CSR value only during a CSR access
         assign o_csr    = i_rdata1 & i_csr_en;
         assign o_csr_pc = i_rdata1;
      end else begin : g_no_csr
         // No trap path, no second write port
         assign o_wdata0 = i_ctrl_rd | (i_alu_rd & i_rd_alu_en) | i_mem_rd;
         assign o_wdata1 = 1'b0;
         assign o_wen0   = rd_wen;
         assign o_wen1   = 1'b0;

         always_comb begin
            wreg0_u.gpr.zero = 1'b0;
            wreg0_u.gpr.idx  = i_rd_waddr;
            wreg1_u.gpr.zero = 1'b0;
            wreg1_u.gpr.idx  = '0;
            rreg1_u.gpr.zero = 1'b0;
            rreg1_u.gpr.idx  = i_rs2_raddr;
         end

         assign o_csr    = 1'b0;
         assign o_csr_pc = 1'b0;
      end
   endgenerate

   assign o_wreg0 = wreg0_u;
   assign o_wreg1 = wreg1_u;
   assign o_rreg1 = rreg1_u;

endmodule

/* rtl/rf_ram_if.sv */
`timescale 1ns/1ps

module rf_ram_if (
   input  logic                       i_clk,
   input  logic                       i_rst_n,
   input  logic                       i_load,
   input  logic                       i_cnt_en,
   input  logic                       i_commit,
   // Addresses and write bits from the steering
   input  logic [rf_pkg::RF_AW-1:0]   i_rreg0,
   input  logic [rf_pkg::RF_AW-1:0]   i_rreg1,
   input  logic [rf_pkg::RF_AW-1:0]   i_wreg0,
   input  logic [rf_pkg::RF_AW-1:0]   i_wreg1,
   input  logic                       i_wen0,
   input  logic                       i_wen1,
   input  logic                       i_wdata0,
   input  logic                       i_wdata1,
   // Registered read words from storage
   input  logic [rf_pkg::RF_XLEN-1:0] i_rword0,
   input  logic [rf_pkg::RF_XLEN-1:0] i_rword1,
   // Storage side
   output logic [rf_pkg::RF_AW-1:0]   o_raddr0,
   output logic [rf_pkg::RF_AW-1:0]   o_raddr1,
   output logic [rf_pkg::RF_AW-1:0]   o_waddr0,
   output logic [rf_pkg::RF_AW-1:0]   o_waddr1,
   output logic                       o_we0,
   output logic                       o_we1,
   output logic [rf_pkg::RF_XLEN-1:0] o_wword0,
   output logic [rf_pkg::RF_XLEN-1:0] o_wword1,
   // Serial read bits
   output logic                       o_rdata0,
   output logic                       o_rdata1
);

   import rf_pkg::*;

   logic [RF_XLEN-1:0] rsh0;
   logic [RF_XLEN-1:0] rsh1;
   logic [RF_XLEN-1:0] wsh0;
   logic [RF_XLEN-1:0] wsh1;
   logic               wen0_q;
   logic               wen1_q;

   // Addresses held stable by the requester for the whole transaction
   assign o_raddr0 = i_rreg0;
   assign o_raddr1 = i_rreg1;
   assign o_waddr0 = i_wreg0;
   assign o_waddr1 = i_wreg1;

   // Read words loaded once, then shifted out LSB first
   always_ff @(posedge i_clk) begin
      if (i_load) begin
         rsh0 <= i_rword0;
         rsh1 <= i_rword1;
      end else if (i_cnt_en) begin
         rsh0 <= {1'b0, rsh0[RF_XLEN-1:1]};
         rsh1 <= {1'b0, rsh1[RF_XLEN-1:1]};
      end
   end

   assign o_rdata0 = rsh0[0];
   assign o_rdata1 = rsh1[0];

   // Write bits enter at the top, bit 0 ends at the bottom
   always_ff @(posedge i_clk) begin
      if (i_cnt_en) begin
         wsh0 <= {i_wdata0, wsh0[RF_XLEN-1:1]};
         wsh1 <= {i_wdata1, wsh1[RF_XLEN-1:1]};
      end
   end

   // Enables sampled in load, used at commit
   always_ff @(posedge i_clk or negedge i_rst_n) begin
      if (!i_rst_n) begin
         wen0_q <= 1'b0;
         wen1_q <= 1'b0;
      end else if (i_load) begin
         wen0_q <= i_wen0;
         wen1_q <= i_wen1;
      end
   end

   assign o_we0    = i_commit & wen0_q;
   assign o_we1    = i_commit & wen1_q;
   assign o_wword0 = wsh0;
   assign o_wword1 = wsh1;

endmodule

/* rtl/rf_ram.sv */
`timescale 1ns/1ps

module rf_ram (
   input  logic                       i_clk,
   input  logic                       i_rst_n,
   input  logic [rf_pkg::RF_AW-1:0]   i_raddr0,
   input  logic [rf_pkg::RF_AW-1:0]   i_raddr1,
   input  logic [rf_pkg::RF_AW-1:0]   i_waddr0,
   input  logic [rf_pkg::RF_AW-1:0]   i_waddr1,
   input  logic                       i_we0,
   input  logic                       i_we1,
   input  logic [rf_pkg::RF_XLEN-1:0] i_wword0,
   input  logic [rf_pkg::RF_XLEN-1:0] i_wword1,
   output logic [rf_pkg::RF_XLEN-1:0] o_rword0,
   output logic [rf_pkg::RF_XLEN-1:0] o_rword1
);

   import rf_pkg::*;

   logic [RF_XLEN-1:0] mem [RF_DEPTH];
   rf_addr_u           chk_raddr1;
   rf_addr_u           chk_waddr0;

   // GPRs and CSRs start at zero
   always_ff @(posedge i_clk or negedge i_rst_n) begin
      if (!i_rst_n) begin
         for (int i = 0; i < RF_DEPTH; i++) begin
            mem[i] <= '0;
         end
      end else begin
         if (i_we0) begin
            mem[i_waddr0] <= i_wword0;
         end
         if (i_we1) begin
            mem[i_waddr1] <= i_wword1;
         end
      end
   end

   // Registered reads return old data on a same-edge write
   always_ff @(posedge i_clk) begin
      o_rword0 <= mem[i_raddr0];
      o_rword1 <= mem[i_raddr1];
   end

   assign chk_raddr1 = i_raddr1;
   assign chk_waddr0 = i_waddr0;

   // Two writes in one commit must target different words
   a_no_write_clash : assert property (@(posedge i_clk) disable iff (!i_rst_n)
      (i_we0 && i_we1) |-> (i_waddr0 != i_waddr1));

   // Either a GPR or a CSR slot behind the 1000 marker
   a_raddr_in_range : assert property (@(posedge i_clk) disable iff (!i_rst_n)
      !chk_raddr1.gpr.zero || (chk_raddr1.csr.marker == CSR_MARKER));

   a_waddr_in_range : assert property (@(posedge i_clk) disable iff (!i_rst_n)
      i_we0 |-> (!chk_waddr0.gpr.zero || (chk_waddr0.csr.marker == CSR_MARKER)));

   // Raw range check on the ports the decoded checks skip
   a_addr_below_depth : assert property (@(posedge i_clk) disable iff (!i_rst_n)
      (i_raddr0 < RF_DEPTH) && (!i_we1 || (i_waddr1 < RF_DEPTH)));

endmodule

/* rtl/serial_rf_top.sv */
`timescale 1ns/1ps

module serial_rf_top #(
   parameter int WITH_CSR = 1
) (
   input  logic                     i_clk,
   input  logic                     i_rst_n,
   // Transaction handshake
   input  logic                     i_go,
   output logic                     o_ready,
   output logic                     o_bit_valid,
   // Operation fields
   input  logic                     i_trap,
   input  logic                     i_mret,
   input  logic                     i_mem_op,
   input  logic                     i_csr_en,
   input  logic [1:0]               i_csr_addr,
   input  logic                     i_rd_wen,
   input  logic [rf_pkg::RF_AW-2:0] i_rd_waddr,
   input  logic [rf_pkg::RF_AW-2:0] i_rs1_raddr,
   input  logic [rf_pkg::RF_AW-2:0] i_rs2_raddr,
   // Serial inputs
   input  logic                     i_mepc,
   input  logic                     i_bufreg_q,
   input  logic                     i_bad_pc,
   input  logic                     i_csr,
   input  logic                     i_ctrl_rd,
   input  logic                     i_alu_rd,
   input  logic                     i_rd_alu_en,
   input  logic                     i_csr_rd,
   input  logic                     i_rd_csr_en,
   input  logic                     i_mem_rd,
   // Serial outputs
   output logic                     o_rs1,
   output logic                     o_rs2,
   output logic                     o_csr,
   output logic                     o_csr_pc
);

   import rf_pkg::*;

   logic               load;
   logic               cnt_en;
   logic               commit;
   logic               cnt_last;
   logic [RF_AW-1:0]   wreg0;
   logic [RF_AW-1:0]   wreg1;
   logic [RF_AW-1:0]   rreg0;
   logic [RF_AW-1:0]   rreg1;
   logic               wen0;
   logic               wen1;
   logic               wdata0;
   logic               wdata1;
   logic               rdata0;
   logic               rdata1;
   logic [RF_AW-1:0]   raddr0;
   logic [RF_AW-1:0]   raddr1;
   logic [RF_AW-1:0]   waddr0;
   logic [RF_AW-1:0]   waddr1;
   logic               we0;
   logic               we1;
   logic [RF_XLEN-1:0] wword0;
   logic [RF_XLEN-1:0] wword1;
   logic [RF_XLEN-1:0] rword0;
   logic [RF_XLEN-1:0] rword1;

   // Bits move only in run
   assign o_bit_valid = cnt_en;

   rf_seq_ctrl u_seq (
      .i_clk      (i_clk),
      .i_rst_n    (i_rst_n),
      .i_go       (i_go),
      .i_cnt_last (cnt_last),
      .o_ready    (o_ready),
      .o_load     (load),
      .o_cnt_en   (cnt_en),
      .o_commit   (commit)
   );

   rf_bit_counter u_cnt (
      .i_clk      (i_clk),
      .i_rst_n    (i_rst_n),
      .i_cnt_en   (cnt_en),
      .o_cnt_last (cnt_last)
   );

   rf_if #(.WITH_CSR(WITH_CSR)) u_rf_if (
      .i_trap      (i_trap),
      .i_mret      (i_mret),
      .i_mepc      (i_mepc),
      .i_mem_op    (i_mem_op),
      .i_bufreg_q  (i_bufreg_q),
      .i_bad_pc    (i_bad_pc),
      .i_csr_en    (i_csr_en),
      .i_csr_addr  (i_csr_addr),
      .i_csr       (i_csr),
      .i_rd_wen    (i_rd_wen),
      .i_rd_waddr  (i_rd_waddr),
      .i_ctrl_rd   (i_ctrl_rd),
      .i_alu_rd    (i_alu_rd),
      .i_rd_alu_en (i_rd_alu_en),
      .i_csr_rd    (i_csr_rd),
      .i_rd_csr_en (i_rd_csr_en),
      .i_mem_rd    (i_mem_rd),
      .i_rs1_raddr (i_rs1_raddr),
      .i_rs2_raddr (i_rs2_raddr),
      .i_rdata0    (rdata0),
      .i_rdata1    (rdata1),
      .o_wreg0     (wreg0),
      .o_wreg1     (wreg1),
      .o_wen0      (wen0),
      .o_wen1      (wen1),
      .o_wdata0    (wdata0),
      .o_wdata1    (wdata1),
      .o_rreg0     (rreg0),
      .o_rreg1     (rreg1),
      .o_rs1       (o_rs1),
      .o_rs2       (o_rs2),
      .o_csr       (o_csr),
      .o_csr_pc    (o_csr_pc)
   );

   rf_ram_if u_ram_if (
      .i_clk    (i_clk),
      .i_rst_n  (i_rst_n),
      .i_load   (load),
      .i_cnt_en (cnt_en),
      .i_commit (commit),
      .i_rreg0  (rreg0),
      .i_rreg1  (rreg1),
      .i_wreg0  (wreg0),
      .i_wreg1  (wreg1),
      .i_wen0   (wen0),
      .i_wen1   (wen1),
      .i_wdata0 (wdata0),
      .i_wdata1 (wdata1),
      .i_rword0 (rword0),
      .i_rword1 (rword1),
      .o_raddr0 (raddr0),
      .o_raddr1 (raddr1),
      .o_waddr0 (waddr0),
      .o_waddr1 (waddr1),
      .o_we0    (we0),
      .o_we1    (we1),
      .o_wword0 (wword0),
      .o_wword1 (wword1),
      .o_rdata0 (rdata0),
      .o_rdata1 (rdata1)
   );

   rf_ram u_ram (
      .i_clk    (i_clk),
      .i_rst_n  (i_rst_n),
      .i_raddr0 (raddr0),
      .i_raddr1 (raddr1),
      .i_waddr0 (waddr0),
      .i_waddr1 (waddr1),
      .i_we0    (we0),
      .i_we1    (we1),
      .i_wword0 (wword0),
      .i_wword1 (wword1),
      .o_rword0 (rword0),
      .o_rword1 (rword1)
   );

endmodule

/* dv/tb_serial_rf.sv */
`timescale 1ns/1ps

module tb_serial_rf;

   import rf_pkg::*;

   // Words per vector line, vector capacity, wait bound in cycles
   localparam int VEC_WORDS  = 9;
   localparam int MAX_VEC    = 64;
   localparam int WAIT_LIMIT = 100;

   logic                clk;
   logic                rst_n;
   logic                go;
   logic                ready;
   logic                bit_valid;
   logic                trap;
   logic                mret;
   logic                mem_op;
   logic                csr_en;
   logic [1:0]          csr_addr;
   logic                rd_wen;
   logic [RF_AW-2:0]    rd_waddr;
   logic [RF_AW-2:0]    rs1_raddr;
   logic [RF_AW-2:0]    rs2_raddr;
   logic                mepc;
   logic                bufreg_q;
   logic                bad_pc;
   logic                csr_in;
   logic                ctrl_rd;
   logic                alu_rd;
   logic                rd_alu_en;
   logic                csr_rd;
   logic                rd_csr_en;
   logic                mem_rd;
   logic                rs1;
   logic                rs2;
   logic                csr_out;
   logic                csr_pc;
   logic [31:0]         vec_mem [0:VEC_WORDS*MAX_VEC-1];
   int                  errors;
   int                  checks;
   int                  num_vec;
   logic                timed_out;

   always #20 clk = ~clk;

   serial_rf_top #(.WITH_CSR(1)) i_dut (
      .i_clk       (clk),
      .i_rst_n     (rst_n),
      .i_go        (go),
      .o_ready     (ready),
      .o_bit_valid (bit_valid),
      .i_trap      (trap),
      .i_mret      (mret),
      .i_mem_op    (mem_op),
      .i_csr_en    (csr_en),
      .i_csr_addr  (csr_addr),
      .i_rd_wen    (rd_wen),
      .i_rd_waddr  (rd_waddr),
      .i_rs1_raddr (rs1_raddr),
      .i_rs2_raddr (rs2_raddr),
      .i_mepc      (mepc),
      .i_bufreg_q  (bufreg_q),
      .i_bad_pc    (bad_pc),
      .i_csr       (csr_in),
      .i_ctrl_rd   (ctrl_rd),
      .i_alu_rd    (alu_rd),
      .i_rd_alu_en (rd_alu_en),
      .i_csr_rd    (csr_rd),
      .i_rd_csr_en (rd_csr_en),
      .i_mem_rd    (mem_rd),
      .o_rs1       (rs1),
      .o_rs2       (rs2),
      .o_csr       (csr_out),
      .o_csr_pc    (csr_pc)
   );

   // Timeout note with the sequencer state, run stops after this
   task automatic report_timeout(input string what, input int v);
      rf_state_e st;
      st = i_dut.u_seq.state;
      $display("Timeout waiting for %s in vector %0d, sequencer in state %s",
               what, v, st.name());
      errors++;
      timed_out = 1'b1;
   endtask

   // Polls o_ready on falling edges
   task automatic wait_ready(input string what, input int v);
      int cnt;
      cnt = 0;
      while (!ready && cnt < WAIT_LIMIT) begin
         @(negedge clk);
         cnt++;
      end
      if (!ready) begin
         report_timeout(what, v);
      end
   endtask

   // Serial bit n of every stimulus word
   // rd sources split the rd word by byte lane: ctrl, ALU, CSR, memory
   task automatic drive_bit(input int n, input logic [31:0] rd_w, input logic [31:0] csr_w,
                            input logic [31:0] mepc_w, input logic [31:0] fault_w);
      int   lane;
      logic rd_b;
      logic csr_b;
      logic mepc_b;
      logic fault_b;
      lane = n / 8;
      if (n < RF_XLEN) begin
         rd_b    = rd_w[n];
         csr_b   = csr_w[n];
         mepc_b  = mepc_w[n];
         fault_b = fault_w[n];
      end else begin
         rd_b    = 1'b0;
         csr_b   = 1'b0;
         mepc_b  = 1'b0;
         fault_b = 1'b0;
      end
      ctrl_rd  <= rd_b & (lane == 0);
      alu_rd   <= rd_b & (lane == 1);
      csr_rd   <= rd_b & (lane == 2);
      mem_rd   <= rd_b & (lane == 3);
      csr_in   <= csr_b;
      mepc     <= mepc_b;
      // Bad PC is the inverted fault word, so MTVAL shows which one landed
      bufreg_q <= fault_b;
      bad_pc   <= ~fault_b;
   endtask

   // One full transaction from a vector line
   task automatic run_vector(input int v);
      logic [31:0] flags;
      logic [31:0] addr;
      logic [31:0] rd_w;
      logic [31:0] csr_w;
      logic [31:0] mepc_w;
      logic [31:0] fault_w;
      logic [31:0] exp_rs1;
      logic [31:0] exp_rs2;
      logic [31:0] exp_pc;
      logic [31:0] exp_csr;
      logic [31:0] got_rs1;
      logic [31:0] got_rs2;
      logic [31:0] got_csr;
      logic [31:0] got_pc;
      int          nbit;
      int          cnt;
      flags   = vec_mem[v*VEC_WORDS+0];
      addr    = vec_mem[v*VEC_WORDS+1];
      rd_w    = vec_mem[v*VEC_WORDS+2];
      csr_w   = vec_mem[v*VEC_WORDS+3];
      mepc_w  = vec_mem[v*VEC_WORDS+4];
      fault_w = vec_mem[v*VEC_WORDS+5];
      exp_rs1 = vec_mem[v*VEC_WORDS+6];
      exp_rs2 = vec_mem[v*VEC_WORDS+7];
      exp_pc  = vec_mem[v*VEC_WORDS+8];
      // CSR output only carries the port 1 word during a CSR access
      exp_csr = flags[16] ? exp_rs2 : 32'h0;
      got_rs1 = '0;
      got_rs2 = '0;
      got_csr = '0;
      got_pc  = '0;

      wait_ready("o_ready before start", v);
      if (timed_out) begin
         return;
      end
      @(posedge clk);
      go        <= 1'b1;
      rd_wen    <= flags[28];
      rd_alu_en <= flags[24];
      rd_csr_en <= flags[20];
      csr_en    <= flags[16];
      trap      <= flags[12];
      mret      <= flags[8];
      mem_op    <= flags[4];
      csr_addr  <= flags[1:0];
      rd_waddr  <= addr[20:16];
      rs1_raddr <= addr[12:8];
      rs2_raddr <= addr[4:0];
      drive_bit(0, rd_w, csr_w, mepc_w, fault_w);
      @(posedge clk);
      go <= 1'b0;

      // First valid bit
      cnt = 0;
      @(negedge clk);
      while (!bit_valid && cnt < WAIT_LIMIT) begin
         @(negedge clk);
         cnt++;
      end
      if (!bit_valid) begin
         report_timeout("first o_bit_valid", v);
         return;
      end

      // Sample bit n mid-cycle, next bit goes out on the edge
      nbit = 0;
      while (bit_valid && nbit < RF_XLEN) begin
         got_rs1[nbit] = rs1;
         got_rs2[nbit] = rs2;
         got_csr[nbit] = csr_out;
         got_pc[nbit]  = csr_pc;
         nbit++;
         @(posedge clk);
         drive_bit(nbit, rd_w, csr_w, mepc_w, fault_w);
         @(negedge clk);
      end
      if (bit_valid || nbit != RF_XLEN) begin
         errors++;
         $display("Vector %0d saw o_bit_valid for %0d cycles instead of %0d",
                  v, nbit + bit_valid, RF_XLEN);
      end

      wait_ready("o_ready after commit", v);
      if (timed_out) begin
         return;
      end

      checks += 3;
      if (got_rs1 !== exp_rs1) begin
         errors++;
         $display("** Error: vector %0d o_rs1 expected %08h got %08h", v, exp_rs1, got_rs1);
      end
      if (got_rs2 !== exp_rs2) begin
         errors++;
         $display("** Error: vector %0d o_rs2 expected %08h got %08h", v, exp_rs2, got_rs2);
      end
      if (got_csr !== exp_csr) begin
         errors++;
         $display("** Error: vector %0d o_csr expected %08h got %08h", v, exp_csr, got_csr);
      end
      // CSR-PC word defined only for trap and mret
      if (flags[12] || flags[8]) begin
         checks++;
         if (got_pc !== exp_pc) begin
            errors++;
            $display("** Error: vector %0d o_csr_pc expected %08h got %08h",
                     v, exp_pc, got_pc);
         end
      end
   endtask

   initial begin
      clk       = 1'b0;
      rst_n     = 1'b0;
      go        = 1'b0;
      trap      = 1'b0;
      mret      = 1'b0;
      mem_op    = 1'b0;
      csr_en    = 1'b0;
      csr_addr  = '0;
      rd_wen    = 1'b0;
      rd_waddr  = '0;
      rs1_raddr = '0;
      rs2_raddr = '0;
      mepc      = 1'b0;
      bufreg_q  = 1'b0;
      bad_pc    = 1'b0;
      csr_in    = 1'b0;
      ctrl_rd   = 1'b0;
      alu_rd    = 1'b0;
      rd_alu_en = 1'b0;
      csr_rd    = 1'b0;
      rd_csr_en = 1'b0;
      mem_rd    = 1'b0;
      errors    = 0;
      checks    = 0;
      timed_out = 1'b0;

      $readmemh("dv/rf_vectors.txt", vec_mem);
      num_vec = 0;
      while (num_vec < MAX_VEC && !$isunknown(vec_mem[num_vec*VEC_WORDS])) begin
         num_vec++;
      end
      if (num_vec == 0) begin
         errors++;
         $display("No vectors were loaded from dv/rf_vectors.txt");
      end

      repeat (16) @(posedge clk);
      rst_n <= 1'b1;

      // Idle after reset: ready up, no bits moving
      @(negedge clk);
      checks++;
      if (ready !== 1'b1 || bit_valid !== 1'b0) begin
         errors++;
         $display("** Error: after reset o_ready expected 1 got %h, o_bit_valid expected 0 got %h",
                  ready, bit_valid);
      end

      for (int v = 0; v < num_vec && !timed_out; v++) begin
         run_vector(v);
      end

      $display("Vectors: %0d, checks: %0d, errors: %0d", num_vec, checks, errors);
      if (errors == 0) begin
         $display("TESTBENCH PASSED");
      end else begin
         $display("TESTBENCH FAILED");
      end
      $finish;
   end

endmodule

/* dv/rf_vectors.txt */
// flags nibbles: rd_wen alu_en rd_csr_en csr_en trap mret mem_op csr_addr; addr bytes: - rd rs1 rs2
// then rd word, csr, mepc, fault words; expected rs1, rs2, csr_pc
// Reset contents, no write enabled
00000000 00000102 DEADBEEF 55555555 00000777 00000888 00000000 00000000 00000000
00010000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000
00010001 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000
00010002 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000
00010003 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000
// x5 write, same-cycle reads see old data
11100000 00050505 12345678 00000000 00000000 00000000 00000000 00000000 00000000
00000000 00000505 00000000 00000000 00000000 00000000 12345678 12345678 00000000
11100000 00050505 A5A50F0F 00000000 00000000 00000000 12345678 12345678 00000000
00000000 00000500 00000000 00000000 00000000 00000000 A5A50F0F 00000000 00000000
// x0 stays zero
11100000 00000000 FFFFFFFF 00000000 00000000 00000000 00000000 00000000 00000000
00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000
// CSR writes then readback
00010000 00000000 00000000 11112222 00000000 00000000 00000000 00000000 00000000
00010001 00000000 00000000 80000100 00000000 00000000 00000000 00000000 00000000
00010002 00000000 00000000 00000040 00000000 00000000 00000000 00000000 00000000
00010003 00000000 00000000 0BADF00D 00000000 00000000 00000000 00000000 00000000
00010000 00000000 00000000 11112222 00000000 00000000 00000000 11112222 00000000
00010001 00000000 00000000 80000100 00000000 00000000 00000000 80000100 00000000
00010002 00000000 00000000 00000040 00000000 00000000 00000000 00000040 00000000
00010003 00000000 00000000 0BADF00D 00000000 00000000 00000000 0BADF00D 00000000
// Traps and mret
00001010 00000500 00000000 00000000 00000200 00001234 A5A50F0F 80000100 80000100
00010003 00000000 00000000 00001234 00000000 00000000 00000000 00001234 00000000
00000100 00000000 00000000 00000000 00000000 00000000 00000000 00000200 00000200
00001000 00000000 00000000 00000000 00000300 00FF00FF 00000000 80000100 80000100
00000100 00000000 00000000 00000000 00000000 00000000 00000000 00000300 00000300
00010003 00000000 00000000 FF00FF00 00000000 00000000 00000000 FF00FF00 00000000
// rd source OR with ALU or CSR source disabled
10100000 00070000 11223344 00000000 00000000 00000000 00000000 00000000 00000000
11000000 00080707 11223344 00000000 00000000 00000000 11220044 11220044 00000000
00000000 00000807 00000000 00000000 00000000 00000000 11003344 11220044 00000000

/* sources.f */
rtl/rf_pkg.sv
rtl/rf_seq_ctrl.sv
rtl/rf_bit_counter.sv
rtl/rf_if.sv
rtl/rf_ram_if.sv
rtl/rf_ram.sv
rtl/serial_rf_top.sv
dv/tb_serial_rf.sv
